/* include/mlp_settings.svh */
`ifndef MLP_SETTINGS_SVH
`define MLP_SETTINGS_SVH

// Network shape.
`define MLP_INPUTS 15
`define MLP_HIDDEN 4
`define MLP_CLASSES 3

// Activations and weights share one signed width.
`define ACT_WIDTH 8
`define FRAC_BITS 6 // Fixed point position of the weight products.
`define ACT_MAX 127

// Register stages inside one neuron and inside the class selector.
`define NODE_LATENCY 3
`define SELECT_LATENCY 1

`endif

/* source/mlpPkg.sv */
`include "mlp_settings.svh"

package mlpPkg;

	typedef logic signed [`ACT_WIDTH-1:0] activation;
	typedef logic signed [2*`ACT_WIDTH-1:0] biasWord;

	// Element i of each vector sits at bits i*ACT_WIDTH and up.
	typedef struct packed
	{
		activation [`MLP_INPUTS-1:0] act;
	} inputVector;

	typedef struct packed
	{
		activation [`MLP_HIDDEN-1:0] act;
	} hiddenVector;

	typedef struct packed
	{
		activation [`MLP_CLASSES-1:0] score;
	} classScores;

	// One row per hidden neuron, one column per network input.
	localparam activation [0:`MLP_HIDDEN-1][0:`MLP_INPUTS-1] hiddenWeights = '{
		'{8'sd0, -8'sd6, 8'sd30, 8'sd2, 8'sd60, 8'sd18, -8'sd42, 8'sd18,
			-8'sd12, 8'sd2, -8'sd6, -8'sd20, -8'sd24, 8'sd20, 8'sd12},
		'{8'sd12, 8'sd40, -8'sd8, -8'sd30, 8'sd6, 8'sd24, 8'sd10, -8'sd16,
			8'sd36, -8'sd4, 8'sd22, 8'sd8, -8'sd28, 8'sd14, -8'sd10},
		'{-8'sd20, 8'sd14, 8'sd48, -8'sd6, -8'sd18, 8'sd30, 8'sd4, 8'sd26,
			-8'sd2, -8'sd36, 8'sd16, 8'sd42, 8'sd6, -8'sd12, 8'sd24},
		'{8'sd34, -8'sd22, 8'sd8, 8'sd50, -8'sd14, -8'sd4, 8'sd28, -8'sd30,
			8'sd18, 8'sd10, -8'sd40, 8'sd2, 8'sd38, 8'sd24, -8'sd8}
	};

	// Biases are in the same fixed point scale as the products.
	localparam biasWord [0:`MLP_HIDDEN-1] hiddenBias = '{
		16'sd0,
		16'sd128,
		-16'sd192,
		16'sd64
	};

	// One row per class, one column per hidden neuron.
	localparam activation [0:`MLP_CLASSES-1][0:`MLP_HIDDEN-1] outputWeights = '{
		'{8'sd40, -8'sd18, 8'sd22, 8'sd10},
		'{-8'sd12, 8'sd36, -8'sd8, 8'sd30},
		'{8'sd16, 8'sd12, 8'sd34, -8'sd24}
	};

	localparam biasWord [0:`MLP_CLASSES-1] outputBias = '{
		16'sd32,
		-16'sd64,
		16'sd0
	};

endpackage

/* source/neuronNode.sv */
`timescale 1ns/10ps
`include "mlp_settings.svh"

module neuronNode #(
	parameter type inVecT = mlpPkg::inputVector,
	parameter mlpPkg::activation [0:($bits(inVecT)/`ACT_WIDTH)-1] weights = '0,
	parameter mlpPkg::biasWord bias = '0
) (
	input logic clk,
	input logic reset,
	input inVecT activations,
	output mlpPkg::activation result
);

	localparam int FAN_IN = $bits(inVecT) / `ACT_WIDTH;
	localparam int PROD_WIDTH = 2 * `ACT_WIDTH;
	// Seven guard bits cover the sum of all products and the bias.
	localparam int SUM_WIDTH = PROD_WIDTH + 7;
	localparam int FIELD_TOP = `FRAC_BITS + `ACT_WIDTH - 1; // Top bit of the output field.

	logic [FAN_IN-1:0][`ACT_WIDTH-1:0] actReg;
	logic signed [PROD_WIDTH-1:0] product [FAN_IN];
	logic signed [SUM_WIDTH-1:0] sumNext;
	logic signed [SUM_WIDTH-1:0] sumReg;
	logic overflow;
	logic roundUp;
	logic [`ACT_WIDTH:0] rounded;
	mlpPkg::activation rectified;

	// Products of the registered inputs feed the sum stage.
	always_comb
	begin
		for (int i = 0; i < FAN_IN; i++)
		begin
			product[i] = PROD_WIDTH'($signed(actReg[i])) * PROD_WIDTH'($signed(weights[i]));
		end
	end

	always_comb
	begin
		sumNext = SUM_WIDTH'(bias); // Sign extended.
		for (int i = 0; i < FAN_IN; i++)
		begin
			sumNext = sumNext + SUM_WIDTH'(product[i]);
		end
	end

	// Rectifier that rounds up only above half a step and clamps at the ceiling.
	always_comb
	begin
		overflow = |sumReg[SUM_WIDTH-2:FIELD_TOP];
		roundUp = sumReg[`FRAC_BITS-1] && (sumReg[`FRAC_BITS-2:0] != '0);
		rounded = {1'b0, sumReg[FIELD_TOP:`FRAC_BITS]} + {{`ACT_WIDTH{1'b0}}, roundUp};
		if (sumReg[SUM_WIDTH-1])
		begin
			rectified = '0; // Negative sums are cut off.
		end
		else if (overflow || (rounded > (`ACT_WIDTH+1)'(`ACT_MAX)))
		begin
			rectified = mlpPkg::activation'(`ACT_MAX);
		end
		else
		begin
			rectified = rounded[`ACT_WIDTH-1:0];
		end
	end

	// Inputs, sum and rectified result each take one stage.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actReg <= '0;
			sumReg <= '0;
			result <= '0;
		end
		else
		begin
			actReg <= activations;
			sumReg <= sumNext;
			result <= rectified;
		end
	end

	resultInRange: assert property (
		@(posedge clk) disable iff (reset)
		(result >= 0) && (result <= `ACT_MAX)
	) else $error("neuron result %0d outside 0..%0d", result, `ACT_MAX);

endmodule

/* source/classSelect.sv */
`timescale 1ns/10ps
`include "mlp_settings.svh"

module classSelect (
	input logic clk,
	input logic reset,
	input mlpPkg::classScores scoresIn,
	input logic sampleValid,
	output mlpPkg::classScores scores,
	output logic [1:0] classIndex,
	output logic resultValid
);

	// Strobe stages ahead of the final output register.
	localparam int PIPE_STAGES = 2 * `NODE_LATENCY + `SELECT_LATENCY - 1;

	logic [PIPE_STAGES-1:0] validPipe;
	logic [1:0] bestIndex;
	mlpPkg::activation bestScore;

	// A strict compare keeps the lowest index when scores tie.
	always_comb
	begin
		bestIndex = '0;
		bestScore = scoresIn.score[0];
		for (int i = 1; i < `MLP_CLASSES; i++)
		begin
			if ($signed(scoresIn.score[i]) > $signed(bestScore))
			begin
				bestIndex = 2'(i);
				bestScore = scoresIn.score[i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			scores <= '0;
			classIndex <= '0;
			validPipe <= '0;
			resultValid <= 1'b0;
		end
		else
		begin
			scores <= scoresIn;
			classIndex <= bestIndex;
			validPipe <= {validPipe[PIPE_STAGES-2:0], sampleValid};
			resultValid <= validPipe[PIPE_STAGES-1]; // Lines up with the registered scores.
		end
	end

	indexInRange: assert property (
		@(posedge clk) disable iff (reset)
		resultValid |-> (classIndex < `MLP_CLASSES)
	) else $error("classIndex %0d out of range", classIndex);

	for (genvar j = 0; j < `MLP_CLASSES; j++)
	begin : gWinner
		winnerIsMax: assert property (
			@(posedge clk) disable iff (reset)
			(resultValid && (classIndex < `MLP_CLASSES))
				|-> ($signed(scores.score[classIndex]) >= $signed(scores.score[j]))
		) else $error("score at index %0d below score %0d", classIndex, j);
	end

endmodule

/* source/mlpClassifier.sv */
`timescale 1ns/10ps
`include "mlp_settings.svh"

module mlpClassifier (
	input logic clk,
	input logic reset,
	input mlpPkg::inputVector sample,
	input logic sampleValid,
	output mlpPkg::classScores scores,
	output logic [1:0] classIndex,
	output logic resultValid
);

	mlpPkg::hiddenVector hidden;
	mlpPkg::classScores rawScores;

	// Hidden layer, every neuron sees the whole sample.
	for (genvar h = 0; h < `MLP_HIDDEN; h++)
	begin : gHidden
		neuronNode #(
			.inVecT(mlpPkg::inputVector),
			.weights(mlpPkg::hiddenWeights[h]),
			.bias(mlpPkg::hiddenBias[h])
		) u_neuron (
			.clk(clk),
			.reset(reset),
			.activations(sample),
			.result(hidden.act[h])
		);
	end

	// Output layer, one neuron per class.
	for (genvar c = 0; c < `MLP_CLASSES; c++)
	begin : gOutput
		neuronNode #(
			.inVecT(mlpPkg::hiddenVector),
			.weights(mlpPkg::outputWeights[c]),
			.bias(mlpPkg::outputBias[c])
		) u_neuron (
			.clk(clk),
			.reset(reset),
			.activations(hidden),
			.result(rawScores.score[c])
		);
	end

	// The strobe skips both layers and is delayed inside the selector.
	classSelect u_classSelect (
		.clk(clk),
		.reset(reset),
		.scoresIn(rawScores),
		.sampleValid(sampleValid),
		.scores(scores),
		.classIndex(classIndex),
		.resultValid(resultValid)
	);

endmodule

/* test/mlpClassifierTb.sv */
`timescale 1ns/10ps
`include "mlp_settings.svh"

module mlpClassifierTb;

	// Counter steps from the edge that drives a strobe to the negedge after its result edge.
	localparam int RESULT_DELAY = 2 * `NODE_LATENCY + `SELECT_LATENCY + 1;

	logic clk;
	logic reset;
	mlpPkg::inputVector sample;
	logic sampleValid;
	mlpPkg::classScores scores;
	logic [1:0] classIndex;
	logic resultValid;

	logic [31:0] lfsrState;
	int cycleCount;
	int samplesSent;
	mlpPkg::classScores expScores[$];
	logic [1:0] expIndex[$];
	int expCycle[$];

	mlpClassifier u_mlpClassifier (
		.clk(clk),
		.reset(reset),
		.sample(sample),
		.sampleValid(sampleValid),
		.scores(scores),
		.classIndex(classIndex),
		.resultValid(resultValid)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic failRun(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "run stopped at %0t", $time);
	endtask

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
		begin
			failRun($sformatf("CHECK FAILED at %0t: %s, got %0h, expected %0h",
				$time, what, actual, expected));
		end
	endtask

	// Galois LFSR with taps at 32, 22, 2 and 1.
	function automatic logic lfsrBit();
		logic out;
		out = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (out)
			lfsrState = lfsrState ^ 32'h8020_0003;
		return out;
	endfunction

	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++)
			value = {value[30:0], lfsrBit()};
		return value;
	endfunction

	// Negative sums give zero and half a step or less rounds down before the clamp.
	function automatic mlpPkg::activation rectify(input int sum);
		int whole;
		int frac;
		if (sum < 0)
			return '0;
		whole = sum >> `FRAC_BITS;
		frac = sum - (whole << `FRAC_BITS);
		if (frac > (1 << (`FRAC_BITS - 1)))
			whole = whole + 1;
		if (whole > `ACT_MAX)
			whole = `ACT_MAX;
		return mlpPkg::activation'(whole);
	endfunction

	function automatic mlpPkg::classScores modelScores(input mlpPkg::inputVector s);
		mlpPkg::hiddenVector hid;
		mlpPkg::classScores out;
		int sum;
		for (int h = 0; h < `MLP_HIDDEN; h++)
		begin
			sum = int'($signed(mlpPkg::hiddenBias[h]));
			for (int i = 0; i < `MLP_INPUTS; i++)
				sum += int'($signed(s.act[i])) * int'($signed(mlpPkg::hiddenWeights[h][i]));
			hid.act[h] = rectify(sum);
		end
		for (int c = 0; c < `MLP_CLASSES; c++)
		begin
			sum = int'($signed(mlpPkg::outputBias[c]));
			for (int j = 0; j < `MLP_HIDDEN; j++)
				sum += int'($signed(hid.act[j])) * int'($signed(mlpPkg::outputWeights[c][j]));
			out.score[c] = rectify(sum);
		end
		return out;
	endfunction

	function automatic logic [1:0] bestClass(input mlpPkg::classScores sc);
		int top;
		logic [1:0] index;
		top = -1000;
		index = '0;
		for (int c = 0; c < `MLP_CLASSES; c++)
			if (int'($signed(sc.score[c])) > top)
				top = int'($signed(sc.score[c]));
		for (int c = `MLP_CLASSES - 1; c >= 0; c--) // Walking down leaves the lowest match.
			if (int'($signed(sc.score[c])) == top)
				index = 2'(c);
		return index;
	endfunction

	function automatic mlpPkg::inputVector uniformSample(input int value);
		mlpPkg::inputVector s;
		for (int i = 0; i < `MLP_INPUTS; i++)
			s.act[i] = mlpPkg::activation'(value);
		return s;
	endfunction

	function automatic mlpPkg::inputVector randomSample();
		mlpPkg::inputVector s;
		logic [31:0] bits;
		for (int i = 0; i < `MLP_INPUTS; i++)
		begin
			bits = randomBits(8);
			s.act[i] = bits[7:0];
		end
		return s;
	endfunction

	task automatic sendSample(input mlpPkg::inputVector s);
		@(posedge clk);
		sample <= s;
		sampleValid <= 1'b1;
		expScores.push_back(modelScores(s));
		expIndex.push_back(bestClass(modelScores(s)));
		expCycle.push_back(cycleCount + RESULT_DELAY);
		samplesSent++;
	endtask

	task automatic idleCycles(input int count);
		repeat (count)
		begin
			@(posedge clk);
			sampleValid <= 1'b0;
		end
	endtask

	task automatic waitForResults();
		int waited;
		waited = 0;
		while (expScores.size() != 0 && waited < 4 * RESULT_DELAY)
		begin
			@(posedge clk);
			waited++;
		end
		if (expScores.size() != 0)
			failRun($sformatf("resultValid never came for %0d samples.", expScores.size()));
	endtask

	task automatic sendAlone(input mlpPkg::inputVector s);
		sendSample(s);
		idleCycles(1);
		waitForResults();
	endtask

	task automatic verifyOutputsZero(input string where);
		checkValue(resultValid, 0, {"resultValid ", where});
		checkValue(classIndex, 0, {"classIndex ", where});
		checkValue(scores, 0, {"scores ", where});
	endtask

	// The datapath runs freely, so scores keep their reset value only until the
	// output neurons pass on their own bias. The strobe must stay low throughout.
	task automatic watchResetRecovery(input string where, input int cycles);
		for (int i = 0; i < cycles; i++)
		begin
			@(negedge clk);
			if (i < `NODE_LATENCY - 1)
				verifyOutputsZero(where);
			else
				checkValue(resultValid, 0, {"resultValid ", where});
		end
	endtask

	// Every result is matched against the oldest sample still in flight.
	always @(negedge clk)
	begin
		if (resultValid === 1'b1)
		begin
			if (expScores.size() == 0)
			begin
				failRun($sformatf("resultValid went high at %0t with no sample in flight.",
					$time));
			end
			else
			begin
				checkValue(scores, expScores.pop_front(), "scores");
				checkValue(classIndex, expIndex.pop_front(), "classIndex");
				checkValue(cycleCount, expCycle.pop_front(), "result cycle");
			end
		end
	end

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount > 20 * samplesSent + 100)
			failRun($sformatf("Timeout after %0d cycles, %0d samples sent.",
				cycleCount, samplesSent));
	end

	task automatic resetStateTest();
		for (int i = 0; i < 3; i++)
		begin
			@(posedge clk);
			if (i == 2)
				reset <= 1'b0;
			@(negedge clk);
			verifyOutputsZero("during reset");
		end
		// No strobe yet, so the monitor catches any stray resultValid.
		watchResetRecovery("after reset", 12);
	endtask

	task automatic singleSampleTest();
		mlpPkg::inputVector s;
		s = uniformSample(0);
		s.act[4] = 8'sd20;
		sendAlone(s);
		for (int i = 0; i < `MLP_INPUTS; i++)
			s.act[i] = mlpPkg::activation'(i * 9 - 63);
		sendAlone(s);
		for (int i = 0; i < `MLP_INPUTS; i++)
			s.act[i] = (i % 2 == 1) ? 8'sd50 : -8'sd50;
		sendAlone(s);
	endtask

	task automatic rectifierEdgeTest();
		mlpPkg::inputVector s;
		sendAlone(uniformSample(127));
		sendAlone(uniformSample(-128));
		s = uniformSample(0);
		s.act[3] = 8'sd16; // First hidden sum is 32 which is exactly half a step.
		sendAlone(s);
		s.act[9] = 8'sd1;
		sendAlone(s);
		s = uniformSample(0);
		s.act[3] = 8'sd48; // First hidden sum is 96 which is one and a half steps.
		sendAlone(s);
		s.act[9] = 8'sd1;
		sendAlone(s);
	endtask

	task automatic tieTest();
		mlpPkg::inputVector s;
		sendAlone(uniformSample(0));
		sendAlone(uniformSample(-128)); // All hidden outputs clamp and all three scores are zero.
		s = uniformSample(0);
		s.act[1] = 8'sd2; // Classes 1 and 2 both score one.
		sendAlone(s);
	endtask

	task automatic streamTest();
		int gap;
		repeat (40)
			sendSample(randomSample());
		repeat (40)
		begin
			sendSample(randomSample());
			gap = int'(randomBits(2));
			idleCycles(gap);
		end
		idleCycles(1);
		waitForResults();
	endtask

	task automatic midStreamResetTest();
		repeat (5)
			sendSample(randomSample());
		@(posedge clk);
		reset <= 1'b1;
		sampleValid <= 1'b0;
		@(posedge clk);
		expScores.delete();
		expIndex.delete();
		expCycle.delete();
		@(posedge clk);
		@(posedge clk);
		reset <= 1'b0;
		watchResetRecovery("after reset in flight", 10);
		sendAlone(randomSample());
	endtask

	initial
	begin
		reset = 1'b1;
		sample = '0;
		sampleValid = 1'b0;
		lfsrState = 32'h6db4_2349;
		cycleCount = 0;
		samplesSent = 0;
		resetStateTest();
		singleSampleTest();
		rectifierEdgeTest();
		tieTest();
		streamTest();
		midStreamResetTest();
		$display("*** PASSED ***");
		$finish;
	end

endmodule

/* sim.f */
+incdir+include
source/mlpPkg.sv
source/neuronNode.sv
source/classSelect.sv
source/mlpClassifier.sv
test/mlpClassifierTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the classifier testbench with Verilator, runs it and scans the log for a failure.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

{ verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module mlpClassifierTb \
	-Mdir obj_dir && ./obj_dir/VmlpClassifierTb; } > "$LOG" 2>&1 \
	|| echo "*** FAILED ***" >> "$LOG"

if grep -qF "*** FAILED ***" "$LOG"; then
	echo "Simulation failed, see $LOG"
	exit 1
fi
echo "Simulation passed, see $LOG"
exit 0
